// File: fir_pkg.sv
package fir_pkg;

    // sample and coefficient widths
    localparam int SAMPLE_W = 18;
    localparam int COEFF_W  = 18;
    localparam int PROD_W   = SAMPLE_W + COEFF_W;

    // 1s17 at the ports, 2s16 inside the pipeline
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // 0s18 coefficients
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // 2s16 * 0s18 gives 2s34
    typedef logic signed [PROD_W-1:0] product_t;

    // product bits kept, back to 1s17
    localparam int PROD_MSB = 34;
    localparam int PROD_LSB = 17;

    localparam int NUM_TAPS    = 15;
    // seven symmetric pairs plus the center tap
    localparam int NUM_PAIRS   = (NUM_TAPS + 1) / 2;
    localparam int TREE_LEVELS = 3;

    // input tap and pre-add stage, then the adder levels
    // the output register adds the last step
    localparam int PIPE_STEPS  = TREE_LEVELS + 2;

    // half of a symmetric low-pass response
    // index 0 is the outermost tap, index 7 the center tap
    localparam coeff_t COEFFS [NUM_PAIRS] = '{
        18'sd561,
        18'sd1662,
        18'sd0,
        -18'sd8677,
        -18'sd10512,
        18'sd20264,
        18'sd75733,
        18'sd104858
    };

    // control states of the stream handshake
    typedef enum logic [1:0] {
        PRIME,
        RUN,
        STALL
    } ctrl_state_t;

endpackage

// File: symfir_bus_if.sv
`timescale 1ns/10ps

interface symfir_bus_if;
    import fir_pkg::*;

    // pipeline advance, one per accepted sample
    logic    step;
    // raw 1s17 sample from the input stream
    sample_t in_sample;
    // registered pre-adder results, center tap last
    sample_t pair_sum [NUM_PAIRS];
    // filter output register
    sample_t y;

    modport delay_mp (
        input  step,
        input  in_sample,
        output pair_sum
    );

    modport tree_mp (
        input  step,
        input  pair_sum,
        output y
    );

    modport ctrl_mp (
        output step
    );

endinterface

// File: symfir_delay_line.sv
`timescale 1ns/10ps

module symfir_delay_line (
    input  logic           sys_clk,
    input  logic           reset,
    symfir_bus_if.delay_mp bus
);
    import fir_pkg::*;

    // sample history, tap[0] is the newest
    sample_t tap [NUM_TAPS];

    // shift register of scaled samples
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                tap[i] <= '0;
            end
        end else if (bus.step) begin
            // 1s17 to 2s16 by arithmetic shift
            // a pair sum then stays in range
            tap[0] <= {bus.in_sample[SAMPLE_W-1], bus.in_sample[SAMPLE_W-1:1]};
            for (int i = 1; i < NUM_TAPS; i++) begin
                tap[i] <= tap[i-1];
            end
        end
    end

    // pre-adders for taps sharing a coefficient
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PAIRS; i++) begin
                bus.pair_sum[i] <= '0;
            end
        end else if (bus.step) begin
            for (int i = 0; i < NUM_PAIRS - 1; i++) begin
                bus.pair_sum[i] <= tap[i] + tap[NUM_TAPS-1-i];
            end
            // center tap has no partner
            bus.pair_sum[NUM_PAIRS-1] <= tap[NUM_PAIRS-1];
        end
    end

endmodule

// File: symfir_mac_tree.sv
`timescale 1ns/10ps

module symfir_mac_tree (
    input  logic          sys_clk,
    input  logic          reset,
    symfir_bus_if.tree_mp bus
);
    import fir_pkg::*;

    // full products, 2s34
    product_t prod [NUM_PAIRS];
    // products cut back to 1s17
    sample_t  term [NUM_PAIRS];

    // adder tree nodes, level by level in one array
    //   0 .. NUM_PAIRS/2-1   first level, fed by term
    //   following entries    each level fed by the one before
    //   NUM_PAIRS-2          root
    sample_t  node [NUM_PAIRS-1];

    // fixed coefficient multipliers
    always_comb begin
        for (int i = 0; i < NUM_PAIRS; i++) begin
            prod[i] = bus.pair_sum[i] * COEFFS[i];
            term[i] = prod[i][PROD_MSB:PROD_LSB];
        end
    end

    // registered adder levels, sums wrap at the sample width
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int k = 0; k < NUM_PAIRS - 1; k++) begin
                node[k] <= '0;
            end
        end else if (bus.step) begin
            for (int k = 0; k < NUM_PAIRS / 2; k++) begin
                node[k] <= term[2*k] + term[2*k+1];
            end
            // node k sums nodes 2k-NUM_PAIRS and 2k-NUM_PAIRS+1
            for (int k = NUM_PAIRS / 2; k < NUM_PAIRS - 1; k++) begin
                node[k] <= node[2*k-NUM_PAIRS] + node[2*k-NUM_PAIRS+1];
            end
        end
    end

    // output register holds still while the stream is stalled
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            bus.y <= '0;
        end else if (bus.step) begin
            bus.y <= node[NUM_PAIRS-2];
        end
    end

endmodule

// File: fill_counter.sv
`timescale 1ns/10ps

module fill_counter (
    input  logic sys_clk,
    input  logic reset,
    input  logic step,
    output logic done
);
    import fir_pkg::*;

    localparam int CNT_W = $clog2(PIPE_STEPS + 1);

    // steps taken since reset, saturating
    logic [CNT_W-1:0] count;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            count <= '0;
        end else if (step && !done) begin
            count <= count + 1'b1;
        end
    end

    // output register now follows real samples
    assign done = (count == CNT_W'(PIPE_STEPS));

endmodule

// File: symfir_ctrl.sv
`timescale 1ns/10ps

module symfir_ctrl (
    input  logic          sys_clk,
    input  logic          reset,
    input  logic          in_valid,
    input  logic          out_ready,
    input  logic          done,
    output logic          in_ready,
    output logic          out_valid,
    symfir_bus_if.ctrl_mp bus
);
    import fir_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        step;

    // accept while the output register is free or being read
    always_comb begin
        case (state)
            PRIME:   in_ready = 1'b1;
            RUN:     in_ready = !out_valid || out_ready;
            STALL:   in_ready = out_ready;
            default: in_ready = 1'b1;
        endcase
    end

    // pipeline moves only on an input transfer
    assign step     = in_valid && in_ready;
    assign bus.step = step;

    always_comb begin
        state_next = state;
        case (state)
            PRIME: begin
                // first real result lands with this step
                if (step && done) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (out_valid && !out_ready) begin
                    state_next = STALL;
                end
            end
            STALL: begin
                if (out_ready) begin
                    state_next = RUN;
                end
            end
            default: state_next = PRIME;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state     <= PRIME;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            // a new result replaces the old one on every step once primed
            if (step && done) begin
                out_valid <= 1'b1;
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// File: symfir_top.sv
`timescale 1ns/10ps

module symfir_top (
    input  logic             sys_clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fir_pkg::sample_t in_data,
    output logic             in_ready,
    output logic             out_valid,
    output fir_pkg::sample_t out_data,
    input  logic             out_ready
);

    // pipeline primed
    logic done;

    symfir_bus_if bus ();

    assign bus.in_sample = in_data;
    assign out_data      = bus.y;

    symfir_ctrl i_symfir_ctrl (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .done      (done),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .bus       (bus.ctrl_mp)
    );

    fill_counter i_fill_counter (
        .sys_clk (sys_clk),
        .reset   (reset),
        .step    (bus.step),
        .done    (done)
    );

    symfir_delay_line i_symfir_delay_line (
        .sys_clk (sys_clk),
        .reset   (reset),
        .bus     (bus.delay_mp)
    );

    symfir_mac_tree i_symfir_mac_tree (
        .sys_clk (sys_clk),
        .reset   (reset),
        .bus     (bus.tree_mp)
    );

endmodule

// File: symfir_chk.sv
`timescale 1ns/10ps

module symfir_chk (
    input logic             sys_clk,
    input logic             reset,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input fir_pkg::sample_t out_data
);

    // control outputs leave reset with the output empty and the input open
    assert property (@(posedge sys_clk) reset |=> (!out_valid && in_ready))
        else $error("control outputs wrong after reset");

    // stalled result must not change or vanish
    assert property (@(posedge sys_clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("output changed while stalled");

    // no input accepted while the output register is blocked
    assert property (@(posedge sys_clk) disable iff (reset)
        (out_valid && !out_ready) |-> !in_ready)
        else $error("in_ready high during output stall");

endmodule

bind symfir_top symfir_chk i_symfir_chk (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: tb_symfir.sv
`timescale 1ns/10ps

module tb_symfir;
    import fir_pkg::*;

    localparam real CLK_PERIOD   = 40.0;
    localparam int  RESET_CYCLES = 16;
    localparam int  NUM_VEC      = 40;
    // trailing zero samples only push results out
    localparam int  CHECK_COUNT  = NUM_VEC - PIPE_STEPS;

    logic    sys_clk;
    logic    reset;
    logic    in_valid;
    sample_t in_data;
    logic    in_ready;
    logic    out_valid;
    sample_t out_data;
    logic    out_ready;

    // even entries are inputs, odd entries expected outputs
    sample_t vec_raw [0:2*NUM_VEC-1];

    integer seed;
    int     in_idx;
    int     out_count;
    logic   in_fire;
    logic   out_fire;

    symfir_top i_symfir_top (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2.0) sys_clk = ~sys_clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // watchdog sized from the vector count
    initial begin
        repeat (RESET_CYCLES + 20 * NUM_VEC) @(posedge sys_clk);
        $display("Timeout: the filter did not deliver all results in time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 86;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        in_idx    = 0;
        out_count = 0;
        $readmemh("symfir_vectors.txt", vec_raw);

        // control outputs must be idle while reset is held
        repeat (RESET_CYCLES - 1) begin
            @(negedge sys_clk);
            check_value("out_valid", out_valid, 0);
            check_value("in_ready", in_ready, 1);
        end
        @(posedge sys_clk);
        #2;
        reset = 1'b0;
        @(negedge sys_clk);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);
        @(posedge sys_clk);

        while (out_count < CHECK_COUNT) begin
            // random input gaps and output stalls
            #2;
            if (in_idx < NUM_VEC) begin
                in_valid = (($random(seed) & 3) != 0);
                in_data  = vec_raw[2*in_idx];
            end else begin
                in_valid = 1'b0;
                in_data  = '0;
            end
            out_ready = (($random(seed) & 7) > 2);

            // sample handshakes mid-cycle where everything is settled
            @(negedge sys_clk);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (in_idx <= PIPE_STEPS) begin
                check_value("out_valid", out_valid, 0);
            end
            if (out_fire) begin
                check_value("out_data", out_data, vec_raw[2*out_count+1]);
                out_count++;
            end
            @(posedge sys_clk);
            if (in_fire) begin
                in_idx++;
            end
        end

        // every sample consumed and no extra result follows
        #2;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        check_value("accepted_samples", in_idx, NUM_VEC);
        repeat (4) begin
            @(negedge sys_clk);
            check_value("out_valid", out_valid, 0);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: symfir_vectors.txt
// two hex columns per line, 18 bits each
// input sample (1s17), expected filter output for that sample (1s17)
10000 0008C
00000 0019F
00000 00000
00000 3F786
00000 3F5BC
00000 013CA
00000 049F5
00000 06666
00000 049F5
00000 013CA
00000 3F5BC
00000 3F786
00000 00000
00000 0019F
00000 0008C
1FFFF 00118
1FFFF 00456
1FFFF 00456
1FFFF 3F363
00000 3DDC3
20000 000FF
00000 092C2
00000 173C0
00000 22D24
00000 230BA
00000 14C2C
00000 00217
00000 3354B
00000 349D8
00000 3CBCF
00000 018DE
00000 01548
00000 00118
00000 3FCC1
00000 3FEE7
00000 00000
00000 00000
00000 00000
00000 00000
00000 00000

// File: build.f
fir_pkg.sv
symfir_bus_if.sv
symfir_delay_line.sv
symfir_mac_tree.sv
fill_counter.sv
symfir_ctrl.sv
symfir_top.sv
symfir_chk.sv
tb_symfir.sv
